//--- regfile_types_pkg.sv
// ------------------------------
// register file types
// bus widths and the packed control structs
// ------------------------------
package regfile_types_pkg;

    typedef logic [7:0]  reg_byte_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] eth_ip_t;
    typedef logic [15:0] eth_port_t;
    typedef logic [23:0] trig_delay_t;

    // first field is the msb, last field is register bit 0
    typedef struct packed {
        logic readback;
        logic res_n;
        logic load;
        logic data;
        logic clock2;
        logic clock1;
    } chip_config_t;

    typedef struct packed {
        logic tsoverflow_sync;
        logic synced;
        logic injection_chip;
        logic injection_gecco;
    } patgen_config_t;

    typedef struct packed {
        logic realign;
        logic trigger_synced;
        logic datamux;
        logic debug;
        logic trigger;
        logic rst;
        logic fifoclear;
        logic enable;
    } readout_control_t;

    typedef struct packed {
        logic trig_ro_reset_n;
        logic untriggered_ro_en;
        logic always_enable_b;
        logic sel_ext;
    } work_mode_t;

    // trig_edge is register bit 0
    typedef struct packed {
        logic [2:0] noise_suppression;
        logic [2:0] source;
        logic       ftdi_trigger;
        logic       trig_edge;
    } trigger_config_t;

endpackage

//--- regfile_map_pkg.sv
// ------------------------------
// register file address map
// addresses, reset values and fixed bytes
// ------------------------------
package regfile_map_pkg;

    import regfile_types_pkg::*;

    // ------------------------------
    // addresses
    // ------------------------------
    localparam reg_addr_t addr_chip_config     = 8'd0;
    localparam reg_addr_t addr_patgen_config   = 8'd5;
    localparam reg_addr_t addr_readout_control = 8'd9;
    localparam reg_addr_t addr_work_mode       = 8'd20;
    localparam reg_addr_t addr_fifo_config     = 8'd21;
    localparam reg_addr_t addr_fifo_data       = 8'd24;
    localparam reg_addr_t addr_eth_ip          = 8'd30;
    localparam reg_addr_t addr_eth_port        = 8'd31;
    localparam reg_addr_t addr_trigger_config  = 8'd40;
    localparam reg_addr_t addr_trigger_delay   = 8'd41;
    localparam reg_addr_t addr_test            = 8'd80;

    // ------------------------------
    // reset values
    // ------------------------------
    // realign set out of reset
    localparam reg_byte_t   rst_readout_control = 8'h80;
    // trigger source 4
    localparam reg_byte_t   rst_trigger_config  = 8'h10;
    // 192.168.1.128
    localparam eth_ip_t     rst_eth_ip          = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam eth_port_t   rst_eth_port        = 16'd1234;
    localparam trig_delay_t rst_trigger_delay   = '0;

    // ------------------------------
    // fixed values
    // ------------------------------
    localparam reg_byte_t test_pattern   = 8'hAB;
    // returned by dataset reads that start on an empty fifo
    localparam reg_byte_t fifo_filler    = 8'hFF;
    localparam int        dataset_reads  = 8;
    // position of the clear bit in the fifo config byte
    localparam int        fifo_clear_bit = 3;

endpackage

//--- readout_fifo.sv
// ------------------------------
// single-clock byte FIFO
// first word fall through, head shown on dout
// ------------------------------
module readout_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         push,
    input  regfile_types_pkg::reg_byte_t din,
    input  logic                         pop,
    output regfile_types_pkg::reg_byte_t dout,
    output logic                         full,
    output logic                         empty
);
    import regfile_types_pkg::*;

    localparam int               ptr_w    = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int               cnt_w    = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

    reg_byte_t        mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_ptr) ? '0 : ptr + 1'b1;
    endfunction

    // push on full and pop on empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == cnt_w'(fifo_depth));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- multibyte_reg.sv
// ------------------------------
// multi-byte shift-in register
// bytes enter at the low end, reads cycle msb first
// ------------------------------
module multibyte_reg #(
    parameter int                     num_bytes   = 2,
    parameter logic [8*num_bytes-1:0] reset_value = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_sel,
    input  logic                         rd_sel,
    input  regfile_types_pkg::reg_byte_t write_data,
    output logic [8*num_bytes-1:0]       value,
    output regfile_types_pkg::reg_byte_t rd_byte
);
    localparam int               pos_w    = (num_bytes > 1) ? $clog2(num_bytes) : 1;
    localparam logic [pos_w-1:0] last_pos = pos_w'(num_bytes - 1);

    // 0 selects the most significant byte
    logic [pos_w-1:0] rd_pos;

    // ------------------------------
    // shift in
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= reset_value;
        end else if (wr_sel) begin
            value <= {value[8*num_bytes-9:0], write_data};
        end
    end

    // ------------------------------
    // read position
    // ------------------------------
    // wraps back to the msb after the last byte
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pos <= '0;
        end else if (rd_sel) begin
            rd_pos <= (rd_pos == last_pos) ? '0 : rd_pos + 1'b1;
        end
    end

    assign rd_byte = value[8*(num_bytes - 1 - int'(rd_pos)) +: 8];

endmodule

//--- control_regs.sv
// ------------------------------
// plain 8-bit control registers
// write decode, read-back and struct outputs
// ------------------------------
module control_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  regfile_types_pkg::reg_addr_t        address,
    input  logic                                write,
    input  regfile_types_pkg::reg_byte_t        write_data,
    output regfile_types_pkg::reg_byte_t        rd_byte,
    output logic                                hit,
    output regfile_types_pkg::chip_config_t     chip_config,
    output regfile_types_pkg::patgen_config_t   patgen_config,
    output regfile_types_pkg::readout_control_t readout_control,
    output regfile_types_pkg::work_mode_t       work_mode,
    output regfile_types_pkg::trigger_config_t  trigger_config
);
    import regfile_types_pkg::*;
    import regfile_map_pkg::*;

    reg_byte_t chip_config_q;
    reg_byte_t patgen_config_q;
    reg_byte_t readout_control_q;
    reg_byte_t work_mode_q;
    reg_byte_t trigger_config_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            chip_config_q     <= '0;
            patgen_config_q   <= '0;
            readout_control_q <= rst_readout_control;
            work_mode_q       <= '0;
            trigger_config_q  <= rst_trigger_config;
        end else if (write) begin
            case (address)
                addr_chip_config:     chip_config_q     <= write_data;
                addr_patgen_config:   patgen_config_q   <= write_data;
                addr_readout_control: readout_control_q <= write_data;
                addr_work_mode:       work_mode_q       <= write_data;
                addr_trigger_config:  trigger_config_q  <= write_data;
                default: ;
            endcase
        end
    end

    // whole byte reads back, upper bits included
    always_comb begin
        hit     = 1'b1;
        rd_byte = '0;
        case (address)
            addr_chip_config:     rd_byte = chip_config_q;
            addr_patgen_config:   rd_byte = patgen_config_q;
            addr_readout_control: rd_byte = readout_control_q;
            addr_work_mode:       rd_byte = work_mode_q;
            addr_trigger_config:  rd_byte = trigger_config_q;
            default:              hit     = 1'b0;
        endcase
    end

    // struct outputs take the low bits
    assign chip_config     = chip_config_q[5:0];
    assign patgen_config   = patgen_config_q[3:0];
    assign readout_control = readout_control_q;
    assign work_mode       = work_mode_q[3:0];
    assign trigger_config  = trigger_config_q;

endmodule

//--- fifo_readout_channel.sv
// ------------------------------
// readout FIFO channel
// dataset framing of 8 reads, config and status byte
// ------------------------------
module fifo_readout_channel #(
    parameter int fifo_depth = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  regfile_types_pkg::reg_addr_t address,
    input  logic                         read,
    input  logic                         write,
    input  regfile_types_pkg::reg_byte_t write_data,
    input  logic                         fifo_wr_en,
    input  regfile_types_pkg::reg_byte_t fifo_din,
    output logic                         fifo_full,
    output regfile_types_pkg::reg_byte_t rd_byte,
    output logic                         hit
);
    import regfile_types_pkg::*;
    import regfile_map_pkg::*;

    localparam int count_w = $clog2(dataset_reads);

    // config bits 7..6
    logic [1:0]         cfg_mode;
    logic               cfg_clear;
    logic               fifo_clear;
    logic               fifo_empty;
    reg_byte_t          fifo_dout;
    logic [count_w-1:0] rd_count;
    logic               empty_at_start;
    logic               data_rd;
    logic               load_from_fifo;
    reg_byte_t          status;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_mode  <= '0;
            cfg_clear <= 1'b0;
        end else if (write && address == addr_fifo_config) begin
            cfg_mode  <= write_data[7:6];
            cfg_clear <= write_data[fifo_clear_bit];
        end
    end

    // clear and reset pass one register stage before the fifo
    always_ff @(posedge clk) begin
        fifo_clear <= rst || cfg_clear;
    end

    // ------------------------------
    // dataset framing
    // ------------------------------
    assign data_rd = read && (address == addr_fifo_data);

    // first read of a dataset decides for all of its reads
    assign load_from_fifo = (rd_count == '0) ? !fifo_empty : !empty_at_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_count       <= '0;
            empty_at_start <= 1'b0;
        end else if (data_rd) begin
            rd_count <= rd_count + 1'b1;
            if (rd_count == '0) begin
                empty_at_start <= fifo_empty;
            end
        end
    end

    readout_fifo #(
        .fifo_depth(fifo_depth)
    ) readout_fifo_i (
        .clk  (clk),
        .clear(fifo_clear),
        .push (fifo_wr_en),
        .din  (fifo_din),
        .pop  (data_rd && load_from_fifo),
        .dout (fifo_dout),
        .full (fifo_full),
        .empty(fifo_empty)
    );

    assign status = {cfg_mode, fifo_full, fifo_empty, cfg_clear, 3'b000};

    always_comb begin
        hit     = 1'b1;
        rd_byte = '0;
        case (address)
            addr_fifo_config: rd_byte = status;
            addr_fifo_data:   rd_byte = load_from_fifo ? fifo_dout : fifo_filler;
            default:          hit     = 1'b0;
        endcase
    end

endmodule

//--- register_file.sv
// ------------------------------
// register file top level
// host byte bus, multi-byte decode, read mux and done
// ------------------------------
module register_file #(
    parameter int fifo_depth = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  regfile_types_pkg::reg_addr_t        address,
    input  logic                                read,
    input  logic                                write,
    input  regfile_types_pkg::reg_byte_t        write_data,
    output regfile_types_pkg::reg_byte_t        read_data,
    output logic                                done,
    output regfile_types_pkg::chip_config_t     chip_config,
    output regfile_types_pkg::patgen_config_t   patgen_config,
    output regfile_types_pkg::readout_control_t readout_control,
    output regfile_types_pkg::work_mode_t       work_mode,
    output regfile_types_pkg::trigger_config_t  trigger_config,
    output regfile_types_pkg::eth_ip_t          eth_ip,
    output regfile_types_pkg::eth_port_t        eth_port,
    output regfile_types_pkg::trig_delay_t      trigger_delay,
    input  logic                                fifo_wr_en,
    input  regfile_types_pkg::reg_byte_t        fifo_din,
    output logic                                fifo_full
);
    import regfile_types_pkg::*;
    import regfile_map_pkg::*;

    reg_byte_t ctrl_byte;
    logic      ctrl_hit;
    reg_byte_t chan_byte;
    logic      chan_hit;
    logic      ip_sel;
    logic      port_sel;
    logic      delay_sel;
    reg_byte_t ip_byte;
    reg_byte_t port_byte;
    reg_byte_t delay_byte;
    reg_byte_t mb_byte;
    logic      mb_hit;

    control_regs control_regs_i (
        .clk            (clk),
        .rst            (rst),
        .address        (address),
        .write          (write),
        .write_data     (write_data),
        .rd_byte        (ctrl_byte),
        .hit            (ctrl_hit),
        .chip_config    (chip_config),
        .patgen_config  (patgen_config),
        .readout_control(readout_control),
        .work_mode      (work_mode),
        .trigger_config (trigger_config)
    );

    fifo_readout_channel #(
        .fifo_depth(fifo_depth)
    ) fifo_readout_channel_i (
        .clk       (clk),
        .rst       (rst),
        .address   (address),
        .read      (read),
        .write     (write),
        .write_data(write_data),
        .fifo_wr_en(fifo_wr_en),
        .fifo_din  (fifo_din),
        .fifo_full (fifo_full),
        .rd_byte   (chan_byte),
        .hit       (chan_hit)
    );

    // ------------------------------
    // multi-byte registers
    // ------------------------------
    assign ip_sel    = (address == addr_eth_ip);
    assign port_sel  = (address == addr_eth_port);
    assign delay_sel = (address == addr_trigger_delay);

    multibyte_reg #(
        .num_bytes  ($bits(eth_ip_t) / 8),
        .reset_value(rst_eth_ip)
    ) eth_ip_i (
        .clk       (clk),
        .rst       (rst),
        .wr_sel    (write && ip_sel),
        .rd_sel    (read && ip_sel),
        .write_data(write_data),
        .value     (eth_ip),
        .rd_byte   (ip_byte)
    );

    multibyte_reg #(
        .num_bytes  ($bits(eth_port_t) / 8),
        .reset_value(rst_eth_port)
    ) eth_port_i (
        .clk       (clk),
        .rst       (rst),
        .wr_sel    (write && port_sel),
        .rd_sel    (read && port_sel),
        .write_data(write_data),
        .value     (eth_port),
        .rd_byte   (port_byte)
    );

    multibyte_reg #(
        .num_bytes  ($bits(trig_delay_t) / 8),
        .reset_value(rst_trigger_delay)
    ) trigger_delay_i (
        .clk       (clk),
        .rst       (rst),
        .wr_sel    (write && delay_sel),
        .rd_sel    (read && delay_sel),
        .write_data(write_data),
        .value     (trigger_delay),
        .rd_byte   (delay_byte)
    );

    always_comb begin
        mb_hit  = ip_sel || port_sel || delay_sel;
        mb_byte = delay_byte;
        if (ip_sel) begin
            mb_byte = ip_byte;
        end else if (port_sel) begin
            mb_byte = port_byte;
        end
    end

    // ------------------------------
    // read data and done
    // ------------------------------
    // unmapped reads keep the old byte but still answer with done
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= '0;
            done      <= 1'b0;
        end else begin
            done <= read;
            if (read) begin
                if (ctrl_hit) begin
                    read_data <= ctrl_byte;
                end else if (chan_hit) begin
                    read_data <= chan_byte;
                end else if (mb_hit) begin
                    read_data <= mb_byte;
                end else if (address == addr_test) begin
                    read_data <= test_pattern;
                end
            end
        end
    end

endmodule

//--- register_file_assertions.sv
// ------------------------------
// register file protocol assertions
// done timing, FIFO flags, test pattern
// ------------------------------
module register_file_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         read,
    input logic                         done,
    input regfile_types_pkg::reg_addr_t address,
    input regfile_types_pkg::reg_byte_t read_data,
    input logic                         fifo_full,
    input logic                         fifo_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    import regfile_map_pkg::*;

    // done answers every read cycle, one cycle late
    done_after_read: assert property (@(posedge clk) disable iff (rst) read |=> done)
        else $error("done did not follow a read cycle");

    no_done_without_read: assert property (@(posedge clk) disable iff (rst) !read |=> !done)
        else $error("done rose without a read cycle");

    flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(fifo_full && fifo_empty))
        else $error("fifo full and empty flags are high together");

    test_read_value: assert property (@(posedge clk) disable iff (rst)
        (read && address == addr_test) |=> (read_data == test_pattern))
        else $error("test register read returned a wrong byte");

endmodule

//--- tb_register_file.sv
// ------------------------------
// register file testbench
// random host traffic checked against a reference model
// ------------------------------
module tb_register_file;
    timeunit 1ns;
    timeprecision 100ps;

    import regfile_types_pkg::*;
    import regfile_map_pkg::*;

    localparam int fifo_depth     = 16;
    localparam int plain_ops      = 40;
    localparam int mb_ops         = 60;
    localparam int fifo_rounds    = 12;
    localparam int cycles_per_op  = 4;
    // reset reads, plain write+read pairs, multi-byte ops, fifo rounds, clear section
    localparam int total_ops      = 27 + 2 * plain_ops + mb_ops
                                  + (fifo_rounds + 3) * (fifo_depth + dataset_reads + 1) + 23;
    localparam int max_cycles     = total_ops * cycles_per_op + 8;

    logic             clk = 1'b0;
    logic             rst;
    reg_addr_t        address;
    logic             read;
    logic             write;
    reg_byte_t        write_data;
    reg_byte_t        read_data;
    logic             done;
    chip_config_t     chip_config;
    patgen_config_t   patgen_config;
    readout_control_t readout_control;
    work_mode_t       work_mode;
    trigger_config_t  trigger_config;
    eth_ip_t          eth_ip;
    eth_port_t        eth_port;
    trig_delay_t      trigger_delay;
    logic             fifo_wr_en;
    reg_byte_t        fifo_din;
    logic             fifo_full;

    integer seed;
    int     error_count = 0;
    int     cycle_count = 0;

    // ------------------------------
    // reference model
    // ------------------------------
    reg_addr_t   plain_addr [5] = '{8'd0, 8'd5, 8'd9, 8'd20, 8'd40};
    reg_byte_t   plain_model [5] = '{8'h00, 8'h00, 8'h80, 8'h00, 8'h10};
    // ip, port, trigger delay
    reg_addr_t   mb_addr [3] = '{8'd30, 8'd31, 8'd41};
    int          mb_len [3] = '{4, 2, 3};
    logic [31:0] mb_val [3] = '{32'hC0A8_0180, 32'd1234, 32'd0};
    int          mb_pos [3] = '{0, 0, 0};
    reg_byte_t   fifo_q [$];
    logic [1:0]  fifo_mode = 2'b00;
    logic        fifo_clear_set = 1'b0;
    int          ds_count = 0;
    logic        ds_has_data = 1'b0;
    reg_byte_t   last_read = 8'h00;

    register_file #(
        .fifo_depth(fifo_depth)
    ) register_file_i (
        .clk            (clk),
        .rst            (rst),
        .address        (address),
        .read           (read),
        .write          (write),
        .write_data     (write_data),
        .read_data      (read_data),
        .done           (done),
        .chip_config    (chip_config),
        .patgen_config  (patgen_config),
        .readout_control(readout_control),
        .work_mode      (work_mode),
        .trigger_config (trigger_config),
        .eth_ip         (eth_ip),
        .eth_port       (eth_port),
        .trigger_delay  (trigger_delay),
        .fifo_wr_en     (fifo_wr_en),
        .fifo_din       (fifo_din),
        .fifo_full      (fifo_full)
    );

    bind register_file register_file_assertions register_file_assertions_i (
        .clk       (clk),
        .rst       (rst),
        .read      (read),
        .done      (done),
        .address   (address),
        .read_data (read_data),
        .fifo_full (fifo_full),
        .fifo_empty(fifo_readout_channel_i.fifo_empty)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        error_count++;
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic reg_byte_t rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic logic [31:0] mb_mask(input int i);
        return (mb_len[i] == 4) ? 32'hFFFF_FFFF : ((32'h1 << (8 * mb_len[i])) - 32'h1);
    endfunction

    function automatic void model_write(input reg_addr_t addr, input reg_byte_t data);
        for (int i = 0; i < 5; i++) begin
            if (addr == plain_addr[i]) begin
                plain_model[i] = data;
            end
        end
        // new byte enters at the low end
        for (int i = 0; i < 3; i++) begin
            if (addr == mb_addr[i]) begin
                mb_val[i] = ((mb_val[i] << 8) | 32'(data)) & mb_mask(i);
            end
        end
        if (addr == 8'd21) begin
            fifo_mode      = data[7:6];
            fifo_clear_set = data[3];
            if (data[3]) begin
                fifo_q.delete();
            end
        end
    endfunction

    // expected read byte, advancing positions and the dataset state
    function automatic reg_byte_t predict_read(input reg_addr_t addr);
        reg_byte_t exp;
        exp = last_read;
        for (int i = 0; i < 5; i++) begin
            if (addr == plain_addr[i]) begin
                exp = plain_model[i];
            end
        end
        for (int i = 0; i < 3; i++) begin
            if (addr == mb_addr[i]) begin
                exp       = 8'(mb_val[i] >> (8 * (mb_len[i] - 1 - mb_pos[i])));
                mb_pos[i] = (mb_pos[i] + 1) % mb_len[i];
            end
        end
        if (addr == 8'd21) begin
            exp = {fifo_mode, fifo_q.size() == fifo_depth, fifo_q.size() == 0,
                   fifo_clear_set, 3'b000};
        end
        if (addr == 8'd24) begin
            if (ds_count == 0) begin
                ds_has_data = (fifo_q.size() != 0);
            end
            if (ds_has_data) begin
                exp = fifo_q.pop_front();
            end else begin
                exp = 8'hFF;
            end
            ds_count = (ds_count + 1) % 8;
        end
        if (addr == 8'd80) begin
            exp = 8'hAB;
        end
        last_read = exp;
        return exp;
    endfunction

    // ------------------------------
    // bus operations
    // ------------------------------
    task automatic do_write(input reg_addr_t addr, input reg_byte_t data);
        @(posedge clk);
        address    <= addr;
        write_data <= data;
        write      <= 1'b1;
        @(posedge clk);
        write <= 1'b0;
        model_write(addr, data);
        @(negedge clk);
    endtask

    task automatic do_read(input reg_addr_t addr, output reg_byte_t data);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        address <= addr;
        read    <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        @(negedge clk);
        while (!done) begin
            wait_cycles++;
            if (wait_cycles > 4) begin
                $display("done never rose after a read at address %0d", addr);
                stop_with_failure();
            end
            @(negedge clk);
        end
        data = read_data;
    endtask

    task automatic read_and_compare(input reg_addr_t addr);
        reg_byte_t expected;
        reg_byte_t got;
        expected = predict_read(addr);
        do_read(addr, got);
        check($sformatf("read_data at address %0d", addr), 32'(got), 32'(expected));
    endtask

    task automatic push_byte(input reg_byte_t data);
        @(posedge clk);
        fifo_wr_en <= 1'b1;
        fifo_din   <= data;
        @(posedge clk);
        fifo_wr_en <= 1'b0;
        fifo_q.push_back(data);
        @(negedge clk);
        check("fifo_full", 32'(fifo_full), 32'(fifo_q.size() == fifo_depth));
    endtask

    task automatic check_outputs();
        check("chip_config", 32'(chip_config), 32'(plain_model[0][5:0]));
        check("chip_config.clock1", 32'(chip_config.clock1), 32'(plain_model[0][0]));
        check("chip_config.readback", 32'(chip_config.readback), 32'(plain_model[0][5]));
        check("patgen_config", 32'(patgen_config), 32'(plain_model[1][3:0]));
        check("patgen_config.injection_gecco", 32'(patgen_config.injection_gecco),
              32'(plain_model[1][0]));
        check("readout_control", 32'(readout_control), 32'(plain_model[2]));
        check("readout_control.realign", 32'(readout_control.realign), 32'(plain_model[2][7]));
        check("work_mode", 32'(work_mode), 32'(plain_model[3][3:0]));
        check("work_mode.sel_ext", 32'(work_mode.sel_ext), 32'(plain_model[3][0]));
        check("trigger_config", 32'(trigger_config), 32'(plain_model[4]));
        check("trigger_config.trig_edge", 32'(trigger_config.trig_edge),
              32'(plain_model[4][0]));
        check("trigger_config.ftdi_trigger", 32'(trigger_config.ftdi_trigger),
              32'(plain_model[4][1]));
        check("trigger_config.source", 32'(trigger_config.source), 32'(plain_model[4][4:2]));
        check("trigger_config.noise_suppression", 32'(trigger_config.noise_suppression),
              32'(plain_model[4][7:5]));
        check("eth_ip", 32'(eth_ip), mb_val[0]);
        check("eth_port", 32'(eth_port), mb_val[1]);
        check("trigger_delay", 32'(trigger_delay), mb_val[2]);
    endtask

    initial begin
        int        idx;
        int        pushes;
        int        need;
        int        free_slots;
        reg_byte_t data;
        seed       = 51;
        rst        = 1'b1;
        address    = '0;
        read       = 1'b0;
        write      = 1'b0;
        write_data = '0;
        fifo_wr_en = 1'b0;
        fifo_din   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // ------------------------------
        // reset values
        // ------------------------------
        check("read_data", 32'(read_data), 32'h0);
        check("done", 32'(done), 32'h0);
        check_outputs();
        for (int i = 0; i < 5; i++) begin
            read_and_compare(plain_addr[i]);
        end
        read_and_compare(8'd21);
        repeat (8) read_and_compare(8'd24);
        // one read past the end of each register to see the wrap
        repeat (5) read_and_compare(8'd30);
        repeat (3) read_and_compare(8'd31);
        repeat (4) read_and_compare(8'd41);
        read_and_compare(8'd80);

        // plain registers and fifo config mode bits
        repeat (plain_ops) begin
            idx  = rand_below(6);
            data = rand_byte();
            if (idx == 5) begin
                data[3] = 1'b0;
                do_write(8'd21, data);
            end else begin
                do_write(plain_addr[idx], data);
            end
            check_outputs();
            read_and_compare((idx == 5) ? 8'd21 : plain_addr[idx]);
        end

        // multi-byte shift-in and cycling reads
        repeat (mb_ops) begin
            idx = rand_below(3);
            if (rand_below(2) == 0) begin
                do_write(mb_addr[idx], rand_byte());
                check_outputs();
            end else begin
                read_and_compare(mb_addr[idx]);
            end
        end

        // ------------------------------
        // fifo datasets
        // ------------------------------
        repeat (fifo_rounds) begin
            if (fifo_q.size() == 0 && rand_below(4) == 0) begin
                pushes = 0;
            end else begin
                free_slots = fifo_depth - fifo_q.size();
                need       = (fifo_q.size() >= 8) ? 0 : 8 - fifo_q.size();
                pushes     = need + rand_below(free_slots - need + 1);
            end
            repeat (pushes) push_byte(rand_byte());
            read_and_compare(8'd21);
            repeat (8) read_and_compare(8'd24);
        end
        while (fifo_q.size() < fifo_depth) begin
            push_byte(rand_byte());
        end
        read_and_compare(8'd21);
        while (fifo_q.size() != 0) begin
            repeat (8) read_and_compare(8'd24);
        end
        repeat (8) read_and_compare(8'd24);

        // fifo clear, unmapped read, test register
        repeat (10) push_byte(rand_byte());
        do_write(8'd21, {fifo_mode, 6'b001000});
        do_write(8'd21, {fifo_mode, 6'b000000});
        read_and_compare(8'd21);
        repeat (8) read_and_compare(8'd24);
        read_and_compare(8'd100);
        read_and_compare(8'd80);

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

//--- verilog.f
regfile_types_pkg.sv
regfile_map_pkg.sv
readout_fifo.sv
multibyte_reg.sv
control_regs.sv
fifo_readout_channel.sv
register_file.sv
register_file_assertions.sv
tb_register_file.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_register_file
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
